//--- Makefile
TOOL = verilator
FLAGS = --binary --timing --timescale 1ns/1ps
TOP = tb_fp_cmp_unit
FILELIST = build.f
LOG = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- build.f
src/fp_pkg.sv
src/fp_classify.sv
src/fp_order.sv
src/fp_writeback.sv
src/fp_cmp_unit.sv
tests/tb_fp_cmp_unit.sv

//--- src/fp_classify.sv
// fp operand classifier
`timescale 1ns/1ps
`default_nettype none

module fp_classify #(
	parameter int exp_w = 8,
	parameter int frac_w = 23
) (
	input logic [exp_w+frac_w:0] operand,
	output logic [fp_pkg::class_w-1:0] class_res
);

	localparam int op_w = exp_w + frac_w + 1;

	logic sign;
	logic [exp_w-1:0] exp_f;
	logic [frac_w-1:0] frac_f;
	logic exp_ones;
	logic exp_zero;
	logic frac_zero;
	logic is_inf;
	logic is_nan;
	logic is_norm;
	logic is_sub;
	logic is_zero;

	assign sign = operand[op_w-1];
	assign exp_f = operand[op_w-2 -: exp_w];
	assign frac_f = operand[frac_w-1:0];

	assign exp_ones = &exp_f;
	assign exp_zero = ~|exp_f;
	assign frac_zero = ~|frac_f;

	assign is_inf = exp_ones & frac_zero;
	assign is_nan = exp_ones & ~frac_zero;
	assign is_norm = ~exp_ones & ~exp_zero;
	assign is_sub = exp_zero & ~frac_zero;	// denormal
	assign is_zero = exp_zero & frac_zero;

	// riscv fclass bit order, bit 0 is -inf
	always_comb begin
		class_res = '0;
		class_res[0] = sign & is_inf;
		class_res[1] = sign & is_norm;
		class_res[2] = sign & is_sub;
		class_res[3] = sign & is_zero;
		class_res[4] = ~sign & is_zero;
		class_res[5] = ~sign & is_sub;
		class_res[6] = ~sign & is_norm;
		class_res[7] = ~sign & is_inf;
		class_res[8] = is_nan & ~frac_f[frac_w-1];	// snan
		class_res[9] = is_nan & frac_f[frac_w-1];	// qnan
	end

endmodule

`default_nettype wire

//--- src/fp_cmp_unit.sv
// fp compare, sign-injection and move unit
`timescale 1ns/1ps
`default_nettype none

module fp_cmp_unit (
	input logic clk,
	input logic rst_n,
	input fp_pkg::fp_word_t frs1,
	input fp_pkg::fp_word_t frs2,
	input logic [4:0] ftype,
	input logic [1:0] fmt,	// 00 single, 11 double
	output logic [fp_pkg::flen-1:0] farithematic_res,
	output logic [fp_pkg::flag_w-1:0] exception_flags,
	output logic fflags_valid
);

	localparam int s_w = fp_pkg::exp_s + fp_pkg::frac_s + 1;
	localparam int d_w = fp_pkg::exp_d + fp_pkg::frac_d + 1;

	logic [s_w-1:0] op1_s;
	logic [s_w-1:0] op2_s;
	logic [d_w-1:0] op1_d;
	logic [d_w-1:0] op2_d;

	logic [fp_pkg::class_w-1:0] class_s;
	logic [fp_pkg::class_w-1:0] class_d;
	logic lt_s;
	logic eq_s;
	logic le_s;
	logic [s_w-1:0] min_res_s;
	logic [s_w-1:0] max_res_s;
	logic nv_quiet_s;
	logic nv_signal_s;
	logic lt_d;
	logic eq_d;
	logic le_d;
	logic [d_w-1:0] min_res_d;
	logic [d_w-1:0] max_res_d;
	logic nv_quiet_d;
	logic nv_signal_d;

	// single view drops the upper half
	assign op1_s = {frs1.s.sign, frs1.s.exp, frs1.s.frac};
	assign op2_s = {frs2.s.sign, frs2.s.exp, frs2.s.frac};
	assign op1_d = {frs1.d.sign, frs1.d.exp, frs1.d.frac};
	assign op2_d = {frs2.d.sign, frs2.d.exp, frs2.d.frac};

	fp_classify #(
		.exp_w(fp_pkg::exp_s),
		.frac_w(fp_pkg::frac_s)
	) fp_classify_s (
		.operand(op1_s),
		.class_res(class_s)
	);

	fp_classify #(
		.exp_w(fp_pkg::exp_d),
		.frac_w(fp_pkg::frac_d)
	) fp_classify_d (
		.operand(op1_d),
		.class_res(class_d)
	);

	fp_order #(
		.exp_w(fp_pkg::exp_s),
		.frac_w(fp_pkg::frac_s)
	) fp_order_s (
		.a(op1_s),
		.b(op2_s),
		.lt(lt_s),
		.eq(eq_s),
		.le(le_s),
		.min_res(min_res_s),
		.max_res(max_res_s),
		.nv_quiet(nv_quiet_s),
		.nv_signal(nv_signal_s)
	);

	fp_order #(
		.exp_w(fp_pkg::exp_d),
		.frac_w(fp_pkg::frac_d)
	) fp_order_d (
		.a(op1_d),
		.b(op2_d),
		.lt(lt_d),
		.eq(eq_d),
		.le(le_d),
		.min_res(min_res_d),
		.max_res(max_res_d),
		.nv_quiet(nv_quiet_d),
		.nv_signal(nv_signal_d)
	);

	fp_writeback fp_writeback_inst (
		.clk(clk),
		.rst_n(rst_n),
		.frs1(frs1),
		.frs2(frs2),
		.ftype(ftype),
		.fmt(fmt),
		.class_s(class_s),
		.class_d(class_d),
		.lt_s(lt_s),
		.eq_s(eq_s),
		.le_s(le_s),
		.min_res_s(min_res_s),
		.max_res_s(max_res_s),
		.nv_quiet_s(nv_quiet_s),
		.nv_signal_s(nv_signal_s),
		.lt_d(lt_d),
		.eq_d(eq_d),
		.le_d(le_d),
		.min_res_d(min_res_d),
		.max_res_d(max_res_d),
		.nv_quiet_d(nv_quiet_d),
		.nv_signal_d(nv_signal_d),
		.farithematic_res(farithematic_res),
		.exception_flags(exception_flags),
		.fflags_valid(fflags_valid)
	);

endmodule

`default_nettype wire

//--- src/fp_order.sv
// fp compare and min/max
`timescale 1ns/1ps
`default_nettype none

module fp_order #(
	parameter int exp_w = 8,
	parameter int frac_w = 23
) (
	input logic [exp_w+frac_w:0] a,
	input logic [exp_w+frac_w:0] b,
	output logic lt,
	output logic eq,
	output logic le,
	output logic [exp_w+frac_w:0] min_res,
	output logic [exp_w+frac_w:0] max_res,
	output logic nv_quiet,
	output logic nv_signal
);

	localparam int op_w = exp_w + frac_w + 1;

	logic a_sign;
	logic b_sign;
	logic [op_w-2:0] a_mag;
	logic [op_w-2:0] b_mag;
	logic a_nan;
	logic b_nan;
	logic a_snan;
	logic b_snan;
	logic both_zero;
	logic mag_lt;
	logic mag_gt;
	logic raw_lt;
	logic raw_eq;
	logic pick_a_min;
	logic [op_w-1:0] canon_nan;

	assign a_sign = a[op_w-1];
	assign b_sign = b[op_w-1];
	assign a_mag = a[op_w-2:0];
	assign b_mag = b[op_w-2:0];

	assign a_nan = (&a[op_w-2 -: exp_w]) & (|a[frac_w-1:0]);
	assign b_nan = (&b[op_w-2 -: exp_w]) & (|b[frac_w-1:0]);
	assign a_snan = a_nan & ~a[frac_w-1];	// quiet bit clear
	assign b_snan = b_nan & ~b[frac_w-1];

	assign both_zero = ~|a_mag & ~|b_mag;	// +0 == -0
	assign mag_lt = a_mag < b_mag;
	assign mag_gt = a_mag > b_mag;

	// sign-magnitude ordering, NaNs handled below
	always_comb begin
		if (both_zero) begin
			raw_lt = 1'b0;
		end else if (a_sign != b_sign) begin
			raw_lt = a_sign;
		end else begin
			raw_lt = a_sign ? mag_gt : mag_lt;	// negatives order backwards
		end
	end

	assign raw_eq = (a == b) | both_zero;

	assign lt = raw_lt & ~a_nan & ~b_nan;
	assign eq = raw_eq & ~a_nan & ~b_nan;
	assign le = lt | eq;

	assign nv_quiet = a_snan | b_snan;
	assign nv_signal = a_nan | b_nan;

	// min/max treat -0 as below +0
	assign pick_a_min = raw_lt | (both_zero & a_sign);
	assign canon_nan = {1'b0, {exp_w{1'b1}}, 1'b1, {(frac_w-1){1'b0}}};

	always_comb begin
		if (a_nan & b_nan) begin
			min_res = canon_nan;
			max_res = canon_nan;
		end else if (a_nan) begin
			min_res = b;
			max_res = b;
		end else if (b_nan) begin
			min_res = a;
			max_res = a;
		end else begin
			min_res = pick_a_min ? a : b;
			max_res = pick_a_min ? b : a;
		end
	end

endmodule

`default_nettype wire

//--- src/fp_pkg.sv
// fp compare unit shared definitions
`default_nettype none

package fp_pkg;

	// operand and format widths
	localparam int flen = 64;
	localparam int exp_s = 8;
	localparam int frac_s = 23;
	localparam int exp_d = 11;
	localparam int frac_d = 52;

	localparam int class_w = 10;	// one-hot fclass vector

	// flags are {invalid, div-by-zero, overflow, underflow, inexact}
	localparam int flag_w = 5;
	localparam int flag_nv = 4;

	localparam logic [1:0] fmt_s = 2'b00;
	localparam logic [1:0] fmt_d = 2'b11;

	// ftype codes kept from the full unit
	localparam logic [4:0] ft_min = 5'd3;
	localparam logic [4:0] ft_max = 5'd4;
	localparam logic [4:0] ft_sgnj = 5'd17;
	localparam logic [4:0] ft_sgnjn = 5'd18;
	localparam logic [4:0] ft_sgnjx = 5'd19;
	localparam logic [4:0] ft_eq = 5'd20;
	localparam logic [4:0] ft_lt = 5'd21;
	localparam logic [4:0] ft_le = 5'd22;
	localparam logic [4:0] ft_class = 5'd23;
	localparam logic [4:0] ft_mv_to_f = 5'd24;	// fmv.w.x / fmv.d.x
	localparam logic [4:0] ft_mv_to_x = 5'd25;	// fmv.x.w / fmv.x.d

	typedef struct packed {
		logic sign;
		logic [exp_d-1:0] exp;
		logic [frac_d-1:0] frac;
	} fp_double_t;

	typedef struct packed {
		logic [flen-exp_s-frac_s-2:0] upper;	// don't care for single ops
		logic sign;
		logic [exp_s-1:0] exp;
		logic [frac_s-1:0] frac;
	} fp_single_t;

	// one register word, seen as a double or as a single in the low half
	typedef union packed {
		fp_double_t d;
		fp_single_t s;
	} fp_word_t;

endpackage

`default_nettype wire

//--- src/fp_writeback.sv
// fp result select and output register
`timescale 1ns/1ps
`default_nettype none

module fp_writeback (
	input logic clk,
	input logic rst_n,
	input fp_pkg::fp_word_t frs1,
	input fp_pkg::fp_word_t frs2,
	input logic [4:0] ftype,
	input logic [1:0] fmt,
	input logic [fp_pkg::class_w-1:0] class_s,
	input logic [fp_pkg::class_w-1:0] class_d,
	input logic lt_s,
	input logic eq_s,
	input logic le_s,
	input logic [fp_pkg::exp_s+fp_pkg::frac_s:0] min_res_s,
	input logic [fp_pkg::exp_s+fp_pkg::frac_s:0] max_res_s,
	input logic nv_quiet_s,
	input logic nv_signal_s,
	input logic lt_d,
	input logic eq_d,
	input logic le_d,
	input logic [fp_pkg::exp_d+fp_pkg::frac_d:0] min_res_d,
	input logic [fp_pkg::exp_d+fp_pkg::frac_d:0] max_res_d,
	input logic nv_quiet_d,
	input logic nv_signal_d,
	output logic [fp_pkg::flen-1:0] farithematic_res,
	output logic [fp_pkg::flag_w-1:0] exception_flags,
	output logic fflags_valid
);

	localparam int s_w = fp_pkg::exp_s + fp_pkg::frac_s + 1;
	localparam int pad_w = fp_pkg::flen - s_w;

	logic [s_w-1:0] sgnj_s;
	logic [s_w-1:0] sgnjn_s;
	logic [s_w-1:0] sgnjx_s;
	logic [fp_pkg::flen-1:0] sgnj_d;
	logic [fp_pkg::flen-1:0] sgnjn_d;
	logic [fp_pkg::flen-1:0] sgnjx_d;
	logic [s_w-1:0] word_s;
	logic [fp_pkg::flen-1:0] res_nxt;
	logic [fp_pkg::flag_w-1:0] flags_nxt;
	logic valid_nxt;
	logic nv;

	// magnitude of frs1 with an injected sign
	assign sgnj_s = {frs2.s.sign, frs1.s.exp, frs1.s.frac};
	assign sgnjn_s = {~frs2.s.sign, frs1.s.exp, frs1.s.frac};
	assign sgnjx_s = {frs1.s.sign ^ frs2.s.sign, frs1.s.exp, frs1.s.frac};
	assign sgnj_d = {frs2.d.sign, frs1.d.exp, frs1.d.frac};
	assign sgnjn_d = {~frs2.d.sign, frs1.d.exp, frs1.d.frac};
	assign sgnjx_d = {frs1.d.sign ^ frs2.d.sign, frs1.d.exp, frs1.d.frac};

	assign word_s = {frs1.s.sign, frs1.s.exp, frs1.s.frac};	// low half for moves

	always_comb begin
		res_nxt = '0;
		flags_nxt = '0;
		valid_nxt = 1'b0;
		nv = 1'b0;
		if (fmt == fp_pkg::fmt_s) begin
			case (ftype)
				fp_pkg::ft_min: begin
					res_nxt = {{pad_w{1'b0}}, min_res_s};
					nv = nv_quiet_s;
					valid_nxt = 1'b1;
				end
				fp_pkg::ft_max: begin
					res_nxt = {{pad_w{1'b0}}, max_res_s};
					nv = nv_quiet_s;
					valid_nxt = 1'b1;
				end
				fp_pkg::ft_sgnj: res_nxt = {{pad_w{1'b0}}, sgnj_s};
				fp_pkg::ft_sgnjn: res_nxt = {{pad_w{1'b0}}, sgnjn_s};
				fp_pkg::ft_sgnjx: res_nxt = {{pad_w{1'b0}}, sgnjx_s};
				fp_pkg::ft_eq: begin
					res_nxt = {{(fp_pkg::flen-1){1'b0}}, eq_s};
					nv = nv_quiet_s;	// quiet compare
					valid_nxt = 1'b1;
				end
				fp_pkg::ft_lt: begin
					res_nxt = {{(fp_pkg::flen-1){1'b0}}, lt_s};
					nv = nv_signal_s;
					valid_nxt = 1'b1;
				end
				fp_pkg::ft_le: begin
					res_nxt = {{(fp_pkg::flen-1){1'b0}}, le_s};
					nv = nv_signal_s;
					valid_nxt = 1'b1;
				end
				fp_pkg::ft_class: res_nxt = {{(fp_pkg::flen-fp_pkg::class_w){1'b0}}, class_s};
				fp_pkg::ft_mv_to_f: res_nxt = {{pad_w{1'b0}}, word_s};
				fp_pkg::ft_mv_to_x: res_nxt = {{pad_w{frs1.s.sign}}, word_s};	// sext bit 31
				default: res_nxt = '0;
			endcase
		end else if (fmt == fp_pkg::fmt_d) begin
			case (ftype)
				fp_pkg::ft_min: begin
					res_nxt = min_res_d;
					nv = nv_quiet_d;
					valid_nxt = 1'b1;
				end
				fp_pkg::ft_max: begin
					res_nxt = max_res_d;
					nv = nv_quiet_d;
					valid_nxt = 1'b1;
				end
				fp_pkg::ft_sgnj: res_nxt = sgnj_d;
				fp_pkg::ft_sgnjn: res_nxt = sgnjn_d;
				fp_pkg::ft_sgnjx: res_nxt = sgnjx_d;
				fp_pkg::ft_eq: begin
					res_nxt = {{(fp_pkg::flen-1){1'b0}}, eq_d};
					nv = nv_quiet_d;
					valid_nxt = 1'b1;
				end
				fp_pkg::ft_lt: begin
					res_nxt = {{(fp_pkg::flen-1){1'b0}}, lt_d};
					nv = nv_signal_d;
					valid_nxt = 1'b1;
				end
				fp_pkg::ft_le: begin
					res_nxt = {{(fp_pkg::flen-1){1'b0}}, le_d};
					nv = nv_signal_d;
					valid_nxt = 1'b1;
				end
				fp_pkg::ft_class: res_nxt = {{(fp_pkg::flen-fp_pkg::class_w){1'b0}}, class_d};
				fp_pkg::ft_mv_to_f: res_nxt = frs1;
				fp_pkg::ft_mv_to_x: res_nxt = frs1;
				default: res_nxt = '0;
			endcase
		end
		flags_nxt[fp_pkg::flag_nv] = nv;	// only invalid can be raised here
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			farithematic_res <= '0;
			exception_flags <= '0;
			fflags_valid <= 1'b0;
		end else begin
			farithematic_res <= res_nxt;
			exception_flags <= flags_nxt;
			fflags_valid <= valid_nxt;
		end
	end

endmodule

`default_nettype wire

//--- tests/fp_cmp_testdata.hex
// ctrl (fmt in bits 9:8 and ftype in bits 4:0) then frs1 then frs2 then expected result
// last column is status with flags in bits 8:4 and valid in bit 0
0015 000000003f800000 ffffffff40000000 0000000000000001 001 // lt s 1 < 2
0016 00000000bf800000 000000003f800000 0000000000000001 001 // le s -1 <= 1
0014 0000000000000000 0000000080000000 0000000000000001 001 // eq s +0 -0
0015 0000000080000000 0000000000000000 0000000000000000 001 // lt s -0 +0
0014 000000007fc00000 000000003f800000 0000000000000000 001 // eq s qnan
0014 000000007f800001 000000003f800000 0000000000000000 101 // eq s snan
0015 000000007fc00000 000000003f800000 0000000000000000 101 // lt s qnan
0315 c000000000000000 bff0000000000000 0000000000000001 001 // lt d -2 < -1
0314 8000000000000000 0000000000000000 0000000000000001 001 // eq d -0 +0
0316 7ff0000000000001 4000000000000000 0000000000000000 101 // le d snan
0314 7ff8000000000000 7ff8000000000000 0000000000000000 001 // eq d qnan qnan
0003 0000000000000000 0000000080000000 0000000080000000 001 // min s +0 -0
0004 0000000080000000 0000000000000000 0000000000000000 001 // max s -0 +0
0003 000000007fc00000 0000000040000000 0000000040000000 001 // min s qnan 2
0004 000000007f800001 00000000ff800001 000000007fc00000 101 // max s two snan
0303 7ff0000000000001 bff0000000000000 bff0000000000000 101 // min d snan -1
0303 7ff8000000000000 fff8000000000000 7ff8000000000000 001 // min d two qnan
0304 3ff0000000000000 7ff8000000000000 3ff0000000000000 001 // max d 1 qnan
0017 00000000ff800000 0000000000000000 0000000000000001 000 // class s -inf
0017 00000000bf800000 0000000000000000 0000000000000002 000
0017 0000000080000001 0000000000000000 0000000000000004 000
0017 0000000080000000 0000000000000000 0000000000000008 000
0017 ffffffff00000000 0000000000000000 0000000000000010 000 // upper half ignored
0017 0000000000000001 0000000000000000 0000000000000020 000
0017 000000003f800000 0000000000000000 0000000000000040 000
0017 000000007f800000 0000000000000000 0000000000000080 000
0017 000000007f800001 0000000000000000 0000000000000100 000
0017 000000007fc00000 0000000000000000 0000000000000200 000 // class s qnan
0317 fff0000000000000 0000000000000000 0000000000000001 000 // class d -inf
0317 c000000000000000 0000000000000000 0000000000000002 000
0317 8000000000000001 0000000000000000 0000000000000004 000
0317 8000000000000000 0000000000000000 0000000000000008 000
0317 0000000000000000 0000000000000000 0000000000000010 000
0317 0000000000000001 0000000000000000 0000000000000020 000
0317 3ff0000000000000 0000000000000000 0000000000000040 000
0317 7ff0000000000000 0000000000000000 0000000000000080 000
0317 7ff0000000000001 0000000000000000 0000000000000100 000
0317 7ff8000000000000 0000000000000000 0000000000000200 000 // class d qnan
0011 12345678bf800000 0000000040000000 000000003f800000 000 // sgnj s
0012 0000000040490fdb 0000000000000000 00000000c0490fdb 000 // sgnjn s
0313 c000000000000000 bff0000000000000 4000000000000000 000 // sgnjx d
0018 deadbeefc0490fdb 0000000000000000 00000000c0490fdb 000 // move to f s
0019 00000000bf800000 0000000000000000 ffffffffbf800000 000 // move to x s sext
0319 8123456789abcdef 0000000000000000 8123456789abcdef 000 // move to x d
0000 000000003f800000 000000003f800000 0000000000000000 000 // dropped add
0305 3ff0000000000000 4000000000000000 0000000000000000 000 // dropped code 5
0114 3ff0000000000000 3ff0000000000000 0000000000000000 000 // fmt 01
0217 3ff0000000000000 0000000000000000 0000000000000000 000 // fmt 10

//--- tests/tb_fp_cmp_unit.sv
// fp compare unit testbench
`timescale 1ns/1ps
`default_nettype none

module tb_fp_cmp_unit;

	localparam int reset_cycles = 4;
	localparam int vec_count = 48;
	localparam int words_per_vec = 5;	// ctrl, frs1, frs2, result, status
	localparam int rand_count = 64;
	localparam int cycle_limit = 2 * (reset_cycles + vec_count + rand_count);

	logic clk;
	logic rst_n;
	logic [63:0] frs1;
	logic [63:0] frs2;
	logic [4:0] ftype;
	logic [1:0] fmt;
	logic [63:0] farithematic_res;
	logic [4:0] exception_flags;
	logic fflags_valid;

	logic [63:0] vec_mem [0:vec_count*words_per_vec-1];
	int pass_count = 0;
	int fail_count = 0;
	int cycle_count = 0;
	integer seed;

	fp_cmp_unit fp_cmp_unit_inst (
		.clk(clk),
		.rst_n(rst_n),
		.frs1(frs1),
		.frs2(frs2),
		.ftype(ftype),
		.fmt(fmt),
		.farithematic_res(farithematic_res),
		.exception_flags(exception_flags),
		.fflags_valid(fflags_valid)
	);

	always #4 clk = ~clk;

	// run limit
	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("simulation timed out after %0d cycles", cycle_count);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// inputs change here and are registered at the next rising edge
	task automatic run_op(input logic [1:0] op_fmt, input logic [4:0] op_type,
			input logic [63:0] a, input logic [63:0] b);
		fmt = op_fmt;
		ftype = op_type;
		frs1 = a;
		frs2 = b;
		@(negedge clk);
	endtask

	task automatic check_outputs(input string name, input logic [63:0] exp_res,
			input logic [4:0] exp_flags, input logic exp_valid);
		if (farithematic_res !== exp_res || exception_flags !== exp_flags
				|| fflags_valid !== exp_valid) begin
			$display("[FAIL] %s expected res=%h flags=%b valid=%b actual res=%h flags=%b valid=%b",
				name, exp_res, exp_flags, exp_valid,
				farithematic_res, exception_flags, fflags_valid);
			fail_count++;
		end else begin
			$display("[PASS] %s", name);
			pass_count++;
		end
	endtask

	initial begin
		int base;
		logic [63:0] ctrl;
		logic [63:0] status;
		logic [31:0] rnd;
		logic [31:0] kind;
		logic [63:0] a;
		logic [63:0] b;
		logic [1:0] op_fmt;
		logic [4:0] op_type;
		logic new_sign;
		logic [63:0] exp_res;

		clk = 1'b0;
		rst_n = 1'b0;
		fmt = fp_pkg::fmt_d;
		ftype = fp_pkg::ft_max;
		frs1 = 64'h7ff0000000000001;	// snan against 1.0 sets every output
		frs2 = 64'h3ff0000000000000;
		seed = 91894;
		$readmemh("tests/fp_cmp_testdata.hex", vec_mem);

		repeat (reset_cycles) @(negedge clk);
		check_outputs("reset", '0, '0, 1'b0);
		rst_n = 1'b1;

		// vector replay
		for (int i = 0; i < vec_count; i++) begin
			base = i * words_per_vec;
			ctrl = vec_mem[base];
			status = vec_mem[base+4];
			run_op(ctrl[9:8], ctrl[4:0], vec_mem[base+1], vec_mem[base+2]);
			check_outputs($sformatf("vector %0d ftype %0d fmt %0d", i, ctrl[4:0], ctrl[9:8]),
				vec_mem[base+3], status[8:4], status[0]);
		end

		// random sign injection
		for (int i = 0; i < rand_count; i++) begin
			rnd = $random(seed);
			a = {$random(seed), $random(seed)};
			b = {$random(seed), $random(seed)};
			kind = rnd % 3;
			op_fmt = rnd[0] ? fp_pkg::fmt_d : fp_pkg::fmt_s;
			if (kind == 0) begin
				op_type = fp_pkg::ft_sgnj;
				new_sign = rnd[0] ? b[63] : b[31];
			end else if (kind == 1) begin
				op_type = fp_pkg::ft_sgnjn;
				new_sign = rnd[0] ? ~b[63] : ~b[31];
			end else begin
				op_type = fp_pkg::ft_sgnjx;
				new_sign = rnd[0] ? a[63] ^ b[63] : a[31] ^ b[31];
			end
			exp_res = rnd[0] ? {new_sign, a[62:0]} : {32'h0, new_sign, a[30:0]};
			run_op(op_fmt, op_type, a, b);
			check_outputs($sformatf("random sign injection %0d ftype %0d fmt %0d",
				i, op_type, op_fmt), exp_res, '0, 1'b0);
		end

		$display("tests passed %0d failed %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire
